// ==== all.f ====
verilog/idi_pkg.sv
verilog/check_pkg.sv
verilog/idi_validity_check_lane.sv
verilog/idi_pkt_stats.sv
verilog/idi_validity_check.sv
test/idi_check_assertions.sv
test/tb_idi_validity_check.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_idi_validity_check -f all.f

out=$(./obj_dir/Vtb_idi_validity_check +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "STATUS: PASS"

// ==== test/tb_idi_validity_check.sv ====
`timescale 1ns/1ns

module tb_idi_validity_check
   import idi_pkg::*;
   import check_pkg::*;
();

   localparam int N_ITEMS     = 40;
   localparam int ITEM_CYCLES = 12; // Longest item is header, 8 beats, idle
   localparam int TEST_CYCLES = N_ITEMS * ITEM_CYCLES + 10;
   localparam int CYCLE_LIMIT = 10 + 4 * TEST_CYCLES + 100;

   logic                 clk;
   logic                 rst_n;
   logic [NUM_LANES-1:0] check_en;
   idi_bus_t             in_bus  [NUM_LANES];
   idi_bus_t             out_bus [NUM_LANES];
   pkt_stats_t           stats   [NUM_LANES];

   logic [15:0]          lfsr;
   int unsigned          exp_long  [NUM_LANES]; // Reference counts
   int unsigned          exp_short [NUM_LANES];
   int unsigned          cycle_cnt;
   int unsigned          pass_cnt;
   int unsigned          fail_cnt;
   int unsigned          assert_base; // Assertion failures already charged to a test

   idi_validity_check u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .check_en (check_en),
      .in_bus   (in_bus),
      .out_bus  (out_bus),
      .stats    (stats)
   );

   bind idi_validity_check idi_check_assertions u_assert (
      .clk      (clk),
      .rst_n    (rst_n),
      .check_en (check_en),
      .in_bus   (in_bus),
      .out_bus  (out_bus),
      .stats    (stats)
   );

   always #10 clk = ~clk;

   // ============================================================
   // Stimulus helpers
   // ============================================================

   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         val  = {val[62:0], fb};
      end
      return val;
   endfunction

   task automatic drive_cycle(input int lane, input idi_bus_t bus);
      @(negedge clk);
      in_bus[lane] = bus;
   endtask

   task automatic send_item(input int lane);
      idi_bus_t   bus;
      logic [1:0] kind;
      int         beats;
      kind                = 2'(take_bits(2));
      bus                 = '0;
      bus.header_en       = 1'b1;
      bus.tunnel_mode_en  = 1'(take_bits(1));
      bus.virtual_channel = 4'(take_bits(4));
      case (kind)
         2'd0: begin // Long packet
            beats         = 1 + int'(take_bits(3));
            bus.data_type = 6'(take_bits(6));
            if ((bus.data_type & LONG_TYPE_MSB_FIELD) == '0) begin
               bus.data_type[4] = 1'b1;
            end
            bus.word_count = 16'(beats * 8);
            drive_cycle(lane, bus);
            for (int k = 0; k < beats; k++) begin
               bus.data_en = 1'b1;
               bus.data    = take_bits(64);
               bus.byte_en = 3'(take_bits(3));
               drive_cycle(lane, bus);
            end
            if (check_en[lane]) exp_long[lane]++;
         end
         2'd1, 2'd2: begin // Short header held one or two cycles
            bus.data_type = 6'(take_bits(6)) & ~LONG_TYPE_MSB_FIELD;
            drive_cycle(lane, bus);
            if (kind == 2'd2) begin
               drive_cycle(lane, bus);
            end else if (check_en[lane]) begin
               exp_short[lane]++;
            end
         end
         default: begin // Stray beats
            beats         = 1 + int'(take_bits(2));
            bus.header_en = 1'b0;
            for (int k = 0; k < beats; k++) begin
               bus.data_en = 1'b1;
               bus.data    = take_bits(64);
               drive_cycle(lane, bus);
            end
         end
      endcase
      drive_cycle(lane, '0);
   endtask

   // ============================================================
   // Result checks
   // ============================================================

   function automatic int check_value(input string name, input logic [STAT_W-1:0] exp,
                                      input logic [STAT_W-1:0] act);
      if (exp !== act) begin
         $display("Fail %s expected 0x%h got 0x%h", name, exp, act);
         return 1;
      end
      return 0;
   endfunction

   task automatic run_test(input string name, input logic [NUM_LANES-1:0] en, input int items);
      int unsigned errs;
      errs = 0;
      @(negedge clk);
      check_en = en;
      repeat (3) @(negedge clk); // Lanes settle into the new mode
      for (int k = 0; k < items; k++) begin
         send_item(int'(take_bits(1)) % NUM_LANES);
      end
      repeat (4) @(negedge clk);
      for (int l = 0; l < NUM_LANES; l++) begin
         errs += check_value($sformatf("stats[%0d].long_cnt", l),
                             STAT_W'(exp_long[l]), stats[l].long_cnt);
         errs += check_value($sformatf("stats[%0d].short_cnt", l),
                             STAT_W'(exp_short[l]), stats[l].short_cnt);
      end
      errs += u_dut.u_assert.fail_cnt - assert_base;
      assert_base = u_dut.u_assert.fail_cnt;
      if (errs == 0) begin
         pass_cnt++;
         $display("Test %s passed", name);
      end else begin
         fail_cnt++;
         $display("Test %s failed with %0d errors", name, errs);
      end
   endtask

   // ============================================================
   // Main sequence
   // ============================================================

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      check_en    = '0;
      lfsr        = 16'd10673;
      pass_cnt    = 0;
      fail_cnt    = 0;
      assert_base = 0;
      for (int l = 0; l < NUM_LANES; l++) begin
         in_bus[l]    = '0;
         exp_long[l]  = 0;
         exp_short[l] = 0;
      end
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      run_test("reset_idle", '0, 0);
      run_test("pass_through", '0, N_ITEMS);
      run_test("lane0_checked", NUM_LANES'(1), N_ITEMS);
      run_test("all_checked", '1, N_ITEMS);

      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout, the run was still busy after %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== test/idi_check_assertions.sv ====
`timescale 1ns/1ns

module idi_check_assertions
   import idi_pkg::*;
   import check_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input logic [NUM_LANES-1:0] check_en,
   input idi_bus_t             in_bus  [NUM_LANES],
   input idi_bus_t             out_bus [NUM_LANES],
   input pkt_stats_t           stats   [NUM_LANES]
);

   // ============================================================
   // Input history per lane
   // ============================================================

   int unsigned          fail_cnt = 0; // Failed assertion count

   logic [NUM_LANES-1:0] hdr_q;
   logic [NUM_LANES-1:0] en_q;       // Checking enabled last cycle
   logic [NUM_LANES-1:0] long_q;     // Last input cycle inside a long packet
   logic [NUM_LANES-1:0] short_q;    // Last input cycle opened a short header
   logic [NUM_LANES-1:0] rise;
   logic [NUM_LANES-1:0] in_long;
   logic [NUM_LANES-1:0] short_rise;
   logic [NUM_LANES-1:0] short_ok;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hdr_q   <= '0;
         en_q    <= '0;
         long_q  <= '0;
         short_q <= '0;
      end else begin
         for (int k = 0; k < NUM_LANES; k++) begin
            hdr_q[k] <= in_bus[k].header_en;
         end
         en_q    <= check_en;
         long_q  <= in_long;
         short_q <= short_rise;
      end
   end

   // ============================================================
   // Forwarding and filtering rules
   // ============================================================

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane

      // Header rise that the checker acts on
      assign rise[i] = in_bus[i].header_en & ~hdr_q[i] & ~in_bus[i].data_en &
                       en_q[i] & check_en[i];
      assign in_long[i] = check_en[i] & in_bus[i].header_en &
                          (long_q[i] | (rise[i] & (|in_bus[i].data_type[5:2])));
      assign short_rise[i] = rise[i] & ~(|in_bus[i].data_type[5:2]);
      assign short_ok[i]   = short_q[i] & ~in_bus[i].header_en & check_en[i];

      a_reset_zero: assert property (@(posedge clk)
         !rst_n |-> (out_bus[i] == '0) && (stats[i] == '0))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("Lane %0d output or statistics not zero during reset", i);
      end

      a_pass_through: assert property (@(posedge clk) disable iff (!rst_n)
         !en_q[i] |-> out_bus[i] == $past(in_bus[i]))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("Lane %0d with checking off did not forward the previous input", i);
      end

      a_long_fwd: assert property (@(posedge clk) disable iff (!rst_n)
         long_q[i] |-> out_bus[i] == $past(in_bus[i]))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("Lane %0d altered or dropped a long packet cycle", i);
      end

      a_short_fwd: assert property (@(posedge clk) disable iff (!rst_n)
         short_ok[i] |-> out_bus[i] == $past(in_bus[i]))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("Lane %0d did not forward a one-cycle short header", i);
      end

      a_filtered: assert property (@(posedge clk) disable iff (!rst_n)
         en_q[i] && !long_q[i] && !short_ok[i] |-> out_bus[i] == '0)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("Lane %0d let malformed traffic through", i);
      end

   end

endmodule

// ==== verilog/idi_validity_check.sv ====
`timescale 1ns/1ns

module idi_validity_check
   import idi_pkg::*;
   import check_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [NUM_LANES-1:0] check_en,
   input  idi_bus_t             in_bus  [NUM_LANES],
   output idi_bus_t             out_bus [NUM_LANES],
   output pkt_stats_t           stats   [NUM_LANES]
);

   // ============================================================
   // Per-lane checker and statistics
   // ============================================================

   logic [NUM_LANES-1:0] long_acc;
   logic [NUM_LANES-1:0] short_acc;

   genvar i;
   generate
      for (i = 0; i < NUM_LANES; i++) begin : g_lane

         idi_validity_check_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .check_en  (check_en[i]),
            .in_bus    (in_bus[i]),
            .out_bus   (out_bus[i]),
            .long_acc  (long_acc[i]),
            .short_acc (short_acc[i])
         );

         idi_pkt_stats u_stats (
            .clk       (clk),
            .rst_n     (rst_n),
            .long_acc  (long_acc[i]),
            .short_acc (short_acc[i]),
            .stats     (stats[i])
         );

      end
   endgenerate

endmodule

// ==== verilog/idi_pkt_stats.sv ====
`timescale 1ns/1ns

module idi_pkt_stats
   import check_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       long_acc,
   input  logic       short_acc,
   output pkt_stats_t stats
);

   // ============================================================
   // Saturating counters
   // ============================================================

   localparam logic [STAT_W-1:0] CNT_MAX = '1;

   logic [STAT_W-1:0] long_cnt;
   logic [STAT_W-1:0] short_cnt;

   function automatic logic [STAT_W-1:0] sat_inc(
      input logic [STAT_W-1:0] cnt,
      input logic              inc
   );
      logic [STAT_W-1:0] res;
      res = cnt;
      if (inc && (cnt != CNT_MAX)) begin
         res = cnt + 1'b1;
      end
      return res;
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         long_cnt <= '0;
      end else begin
         long_cnt <= sat_inc(long_cnt, long_acc);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         short_cnt <= '0;
      end else begin
         short_cnt <= sat_inc(short_cnt, short_acc);
      end
   end

   // ============================================================
   // Output
   // ============================================================

   assign stats.long_cnt  = long_cnt;
   assign stats.short_cnt = short_cnt;

endmodule

// ==== verilog/idi_validity_check_lane.sv ====
`timescale 1ns/1ns

module idi_validity_check_lane
   import idi_pkg::*;
   import check_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     check_en,
   input  idi_bus_t in_bus,
   output idi_bus_t out_bus,
   output logic     long_acc,
   output logic     short_acc
);

   // ============================================================
   // Input delay
   // ============================================================

   idi_bus_t    in_d;       // Previous cycle of the bus
   logic        hdr_prev;   // Previous header level
   lane_state_e state;
   lane_state_e state_nxt;

   logic        hdr_rise;
   logic        hdr_fall;
   logic        long_hdr;
   logic        short_hdr;
   logic        short_fwd;
   logic        long_start;
   logic        fwd;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_d     <= '0;
         hdr_prev <= 1'b0;
      end else begin
         in_d     <= in_bus;
         hdr_prev <= in_bus.header_en;
      end
   end

   // ============================================================
   // Header edge decode
   // ============================================================

   assign hdr_rise = in_bus.header_en & ~hdr_prev;
   assign hdr_fall = hdr_prev & ~in_bus.header_en;

   // A header only counts when no payload beat shares its cycle
   assign long_hdr  = hdr_rise & ~in_bus.data_en &
                      (|(in_bus.data_type & LONG_TYPE_MSB_FIELD));
   assign short_hdr = hdr_rise & ~in_bus.data_en &
                      ~(|(in_bus.data_type & LONG_TYPE_MSB_FIELD));

   // ============================================================
   // Framing FSM
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= CHK_OFF;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      if (!check_en) begin
         state_nxt = CHK_OFF;
      end else begin
         case (state)
            CHK_OFF: begin
               state_nxt = CHK_IDLE;
            end
            CHK_IDLE, CHK_SHORT_END: begin
               if (long_hdr) begin
                  state_nxt = CHK_LONG;
               end else if (short_hdr) begin
                  state_nxt = CHK_SHORT;
               end else begin
                  state_nxt = CHK_IDLE;
               end
            end
            CHK_LONG: begin
               if (hdr_fall) begin
                  state_nxt = CHK_IDLE;
               end
            end
            CHK_SHORT: begin
               // Header must drop after exactly one cycle
               if (!in_bus.header_en) begin
                  state_nxt = CHK_SHORT_END;
               end else begin
                  state_nxt = CHK_IDLE;
               end
            end
            default: begin
               state_nxt = CHK_OFF;
            end
         endcase
      end
   end

   // ============================================================
   // Acceptance pulses
   // ============================================================

   assign short_fwd  = (state == CHK_SHORT) && (state_nxt == CHK_SHORT_END);
   assign long_start = (state != CHK_LONG) && (state_nxt == CHK_LONG);

   // Aligned with the first cycle spent in CHK_LONG
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         long_acc <= 1'b0;
      end else begin
         long_acc <= long_start;
      end
   end

   assign short_acc = short_fwd;

   // ============================================================
   // Output select
   // ============================================================

   assign fwd = (state == CHK_OFF) || (state == CHK_LONG) || short_fwd;

   always_comb begin
      if (fwd) begin
         out_bus = in_d;
      end else begin
         out_bus = '0; // Filtered cycle
      end
   end

endmodule

// ==== verilog/check_pkg.sv ====
package check_pkg;

   // ============================================================
   // Lane checker states
   // ============================================================

   typedef enum logic [2:0] {
      CHK_OFF       = 3'd0, // Checking disabled, pass through
      CHK_IDLE      = 3'd1,
      CHK_LONG      = 3'd2, // Long packet open
      CHK_SHORT     = 3'd3, // Short header seen, length pending
      CHK_SHORT_END = 3'd4
   } lane_state_e;

   // ============================================================
   // Packet statistics
   // ============================================================

   localparam int STAT_W = 16;

   typedef struct packed {
      logic [STAT_W-1:0] long_cnt;
      logic [STAT_W-1:0] short_cnt;
   } pkt_stats_t;

endpackage

// ==== verilog/idi_pkg.sv ====
package idi_pkg;

   // ============================================================
   // Lane count and field widths
   // ============================================================

   localparam int NUM_LANES = 2;

   localparam int DT_W   = 6;  // Data type
   localparam int WC_W   = 16; // Word count
   localparam int VC_W   = 4;  // Virtual channel
   localparam int DATA_W = 64; // Payload beat
   localparam int BE_W   = 3;  // Byte enable code

   // ============================================================
   // Data type decoding
   // ============================================================

   // Data types with bits 5..2 all zero are short packets (frame and
   // line sync codes). Anything above that limit opens a long packet.
   localparam logic [DT_W-1:0] LONG_TYPE_MSB_FIELD = 6'b11_1100;

   // ============================================================
   // One lane of the IDI bus
   // ============================================================

   typedef struct packed {
      logic              tunnel_mode_en;
      logic              header_en;       // Header level
      logic [DT_W-1:0]   data_type;
      logic [WC_W-1:0]   word_count;
      logic [VC_W-1:0]   virtual_channel;
      logic [DATA_W-1:0] data;
      logic              data_en;         // Payload beat valid
      logic [BE_W-1:0]   byte_en;
   } idi_bus_t;

endpackage
